/* flist.f */
+incdir+.
key_extract_pkg.sv
key_table.sv
key_field_select.sv
predicate_eval.sv
key_assemble.sv
key_extract.sv
tb_key_extract.sv

/* key_assemble.sv */
// PHV and mask delay, key build from selected fields and predicate bit
`include "key_extract_defines.svh"

module key_assemble
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  phv_t             phv_in,
    input  logic             phv_valid_in,
    input  key_t             mask_entry,
    input  logic [`W_6B-1:0] field_6b,
    input  logic [`W_4B-1:0] field_4b,
    input  logic [`W_2B-1:0] field_2b,
    input  logic             pred_bit,
    output phv_t             phv_out,
    output logic             phv_valid_out,
    output key_t             key_out,
    output logic             key_valid_out,
    output key_t             key_mask_out
);

    phv_t       phv_d [2];
    logic [1:0] valid_d;
    key_t       mask_d;
    key_t       key_next;

    // only this stage's predicate bit is set
    always_comb begin
        key_next = '0;
        key_next.f6 = field_6b;
        key_next.f4 = field_4b;
        key_next.f2 = field_2b;
        key_next.pred[`NUM_COM-1-STAGE_ID] = pred_bit;
    end

    always_ff @(posedge clk) begin
        phv_d[0]     <= phv_in;
        phv_d[1]     <= phv_d[0];
        phv_out      <= phv_d[1];
        mask_d       <= mask_entry;
        key_mask_out <= mask_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d       <= '0;
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
            key_out       <= '0;
        end else begin
            valid_d       <= {valid_d[0], phv_valid_in};
            phv_valid_out <= valid_d[1];
            key_valid_out <= valid_d[1];
            key_out       <= valid_d[1] ? key_next : '0;
        end
    end

endmodule

/* key_extract.sv */
// key extractor top: table, field select, predicate and assembly stages
`include "key_extract_defines.svh"

module key_extract
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  phv_t       phv_in,
    input  logic       phv_valid_in,
    input  logic       cfg_req,
    input  cfg_write_t cfg,
    output logic       cfg_ack,
    output phv_t       phv_out,
    output logic       phv_valid_out,
    output key_t       key_out,
    output logic       key_valid_out,
    output key_t       key_mask_out
);

    off_entry_t       off_entry;
    key_t             mask_entry;
    logic [`W_6B-1:0] field_6b;
    logic [`W_4B-1:0] field_4b;
    logic [`W_2B-1:0] field_2b;
    logic             pred_bit;

    key_table u_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_req    (cfg_req),
        .cfg        (cfg),
        .phv_in     (phv_in),
        .cfg_ack    (cfg_ack),
        .off_entry  (off_entry),
        .mask_entry (mask_entry)
    );

    key_field_select u_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .phv_in    (phv_in),
        .off_entry (off_entry),
        .field_6b  (field_6b),
        .field_4b  (field_4b),
        .field_2b  (field_2b)
    );

    predicate_eval #(
        .STAGE_ID (STAGE_ID)
    ) u_pred (
        .clk      (clk),
        .rst_n    (rst_n),
        .phv_in   (phv_in),
        .pred_bit (pred_bit)
    );

    key_assemble #(
        .STAGE_ID (STAGE_ID)
    ) u_assemble (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .mask_entry    (mask_entry),
        .field_6b      (field_6b),
        .field_4b      (field_4b),
        .field_2b      (field_2b),
        .pred_bit      (pred_bit),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

/* key_extract_defines.svh */
// container counts and widths, PHV and key lengths, tenant position, table depth
`ifndef KEY_EXTRACT_DEFINES_SVH
`define KEY_EXTRACT_DEFINES_SVH

// containers per size
`define NUM_CONT 8

// container widths in bits
`define W_6B 48
`define W_4B 32
`define W_2B 16

// comparator words, one per stage
`define NUM_COM 5
`define W_COM 20

`define W_META 256

// 384 + 256 + 128 + 100 + 256
`define PHV_LEN (`NUM_CONT*(`W_6B+`W_4B+`W_2B) + `NUM_COM*`W_COM + `W_META)

// three fields plus one predicate bit per stage
`define KEY_LEN (`W_6B + `W_4B + `W_2B + `NUM_COM)

// upper nibble of the low vlan byte
`define TENANT_LSB 133

// one table entry per tenant
`define NUM_TENANT 16

`endif

/* key_extract_pkg.sv */
// shared types: PHV layout, key, comparator word and operand union, table entries
`include "key_extract_defines.svh"

package key_extract_pkg;

    localparam int IDX_W    = $clog2(`NUM_CONT);
    localparam int TENANT_W = $clog2(`NUM_TENANT);

    // comparator op codes
    localparam logic [1:0] OP_GT     = 2'b00;
    localparam logic [1:0] OP_GE     = 2'b01;
    localparam logic [1:0] OP_EQ     = 2'b10;
    localparam logic [1:0] OP_ALWAYS = 2'b11;

    // operand size codes, 11 reads as zero
    localparam logic [1:0] SZ_2B = 2'b00;
    localparam logic [1:0] SZ_4B = 2'b01;
    localparam logic [1:0] SZ_6B = 2'b10;

    typedef struct packed {
        logic [2:0]       unused;
        logic [1:0]       size;
        logic [IDX_W-1:0] idx;
    } operand_ref_t;

    // same byte, immediate value or container reference
    typedef union packed {
        logic [7:0]   imm;
        operand_ref_t cont_ref;
    } operand_body_u;

    typedef struct packed {
        logic          is_imm;
        operand_body_u body;
    } operand_t;

    typedef struct packed {
        logic [1:0] op;
        operand_t   opd1;
        operand_t   opd2;
    } com_word_t;

    // index 7 and comparator word 0 sit highest
    typedef struct packed {
        logic [`NUM_CONT-1:0][`W_6B-1:0] c6;
        logic [`NUM_CONT-1:0][`W_4B-1:0] c4;
        logic [`NUM_CONT-1:0][`W_2B-1:0] c2;
        com_word_t [0:`NUM_COM-1]        com;
        logic [`W_META-1:0]              meta;
    } phv_t;

    typedef struct packed {
        logic [`W_6B-1:0]    f6;
        logic [`W_4B-1:0]    f4;
        logic [`W_2B-1:0]    f2;
        logic [`NUM_COM-1:0] pred;
    } key_t;

    typedef struct packed {
        logic [IDX_W-1:0] idx_6b;
        logic [IDX_W-1:0] idx_4b;
        logic [IDX_W-1:0] idx_2b;
    } off_entry_t;

    typedef struct packed {
        logic                sel_mask;
        logic [TENANT_W-1:0] tenant;
        off_entry_t          off;
        key_t                mask;
    } cfg_write_t;

endpackage

/* key_field_select.sv */
// container capture and per-size field selection by offset entry
`include "key_extract_defines.svh"

module key_field_select
    import key_extract_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  phv_t             phv_in,
    input  off_entry_t       off_entry,
    output logic [`W_6B-1:0] field_6b,
    output logic [`W_4B-1:0] field_4b,
    output logic [`W_2B-1:0] field_2b
);

    logic [`NUM_CONT-1:0][`W_6B-1:0] cont_6b;
    logic [`NUM_CONT-1:0][`W_4B-1:0] cont_4b;
    logic [`NUM_CONT-1:0][`W_2B-1:0] cont_2b;

    // first stage, aligned with the table read
    always_ff @(posedge clk) begin
        cont_6b <= phv_in.c6;
        cont_4b <= phv_in.c4;
        cont_2b <= phv_in.c2;
    end

    // second stage, one container of each size
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            field_6b <= '0;
            field_4b <= '0;
            field_2b <= '0;
        end else begin
            field_6b <= cont_6b[off_entry.idx_6b];
            field_4b <= cont_4b[off_entry.idx_4b];
            field_2b <= cont_2b[off_entry.idx_2b];
        end
    end

endmodule

/* key_table.sv */
// per-tenant offset and mask tables, req/ack config write, registered tenant read
`include "key_extract_defines.svh"

module key_table
    import key_extract_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_req,
    input  cfg_write_t cfg,
    input  phv_t       phv_in,
    output logic       cfg_ack,
    output off_entry_t off_entry,
    output key_t       mask_entry
);

    off_entry_t          off_tab  [`NUM_TENANT];
    key_t                mask_tab [`NUM_TENANT];
    logic [TENANT_W-1:0] tenant;
    logic                wr_fire;

    // tenant taken straight from the incoming PHV
    assign tenant = phv_in[`TENANT_LSB +: TENANT_W];

    // one write per request, only while ack is still low
    assign wr_fire = cfg_req && !cfg_ack;

    // ack follows req one edge later, giving the four-phase handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ack <= 1'b0;
        end else begin
            cfg_ack <= cfg_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            off_tab <= '{default: '0};
        end else if (wr_fire && !cfg.sel_mask) begin
            off_tab[cfg.tenant] <= cfg.off;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_tab <= '{default: '0};
        end else if (wr_fire && cfg.sel_mask) begin
            mask_tab[cfg.tenant] <= cfg.mask;
        end
    end

    // read sees the table before any write on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            off_entry  <= '0;
            mask_entry <= '0;
        end else begin
            off_entry  <= off_tab[tenant];
            mask_entry <= mask_tab[tenant];
        end
    end

endmodule

/* predicate_eval.sv */
// comparator operand decode and compare for one stage's predicate bit
module predicate_eval
    import key_extract_pkg::*;
#(
    parameter int STAGE_ID = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  phv_t phv_in,
    output logic pred_bit
);

    com_word_t  com_word;
    logic [7:0] opd1_val;
    logic [7:0] opd2_val;
    logic [7:0] opd1_q;
    logic [7:0] opd2_q;
    logic [1:0] op_q;

    // low byte of the named container, or the immediate
    function automatic logic [7:0] resolve(operand_t opd, phv_t phv);
        logic [7:0] val;
        if (opd.is_imm) begin
            val = opd.body.imm;
        end else begin
            case (opd.body.cont_ref.size)
                SZ_6B:   val = phv.c6[opd.body.cont_ref.idx][7:0];
                SZ_4B:   val = phv.c4[opd.body.cont_ref.idx][7:0];
                SZ_2B:   val = phv.c2[opd.body.cont_ref.idx][7:0];
                default: val = 8'h00;
            endcase
        end
        return val;
    endfunction

    assign com_word = phv_in.com[STAGE_ID];
    assign opd1_val = resolve(com_word.opd1, phv_in);
    assign opd2_val = resolve(com_word.opd2, phv_in);

    always_ff @(posedge clk) begin
        opd1_q <= opd1_val;
        opd2_q <= opd2_val;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= OP_GT;
        end else begin
            op_q <= com_word.op;
        end
    end

    // unsigned compare on the byte operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_bit <= 1'b0;
        end else begin
            case (op_q)
                OP_GT:   pred_bit <= (opd1_q > opd2_q);
                OP_GE:   pred_bit <= (opd1_q >= opd2_q);
                OP_EQ:   pred_bit <= (opd1_q == opd2_q);
                default: pred_bit <= 1'b1;
            endcase
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the key extractor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f flist.f \
    --top-module tb_key_extract -o tb_key_extract_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_key_extract_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$log"; then
    exit 1
fi
if ! grep -q "Everything OK" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
exit 0

/* tb_key_model.svh */
// LFSR stimulus source, PHV and key builders, reference model for key, predicate and mask
`ifndef TB_KEY_MODEL_SVH
`define TB_KEY_MODEL_SVH

// galois form, shifting right
function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
endfunction

// one LFSR step per bit, n up to 32
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic phv_t random_phv();
    logic [`PHV_LEN-1:0] v;
    logic [31:0]         r;
    for (int i = 0; i < `PHV_LEN; i++) begin
        r = rand_bits(1);
        v[i] = r[0];
    end
    return v;
endfunction

function automatic key_t random_key();
    logic [`KEY_LEN-1:0] v;
    logic [31:0]         r;
    for (int i = 0; i < `KEY_LEN; i++) begin
        r = rand_bits(1);
        v[i] = r[0];
    end
    return v;
endfunction

function automatic operand_t make_imm(logic [7:0] v);
    return {1'b1, v};
endfunction

function automatic operand_t make_ref(logic [1:0] size, logic [2:0] idx);
    return {1'b0, 3'b000, size, idx};
endfunction

// bit 8 immediate flag, then size code in 4:3 and index in 2:0
function automatic logic [7:0] opd_byte(operand_t o, phv_t p);
    logic [8:0] raw;
    logic [7:0] v;
    raw = o;
    if (raw[8]) begin
        v = raw[7:0];
    end else if (raw[4:3] == 2'b10) begin
        v = p.c6[raw[2:0]][7:0];
    end else if (raw[4:3] == 2'b01) begin
        v = p.c4[raw[2:0]][7:0];
    end else if (raw[4:3] == 2'b00) begin
        v = p.c2[raw[2:0]][7:0];
    end else begin
        v = 8'h00;
    end
    return v;
endfunction

function automatic logic ref_pred(com_word_t w, phv_t p);
    logic [7:0] a;
    logic [7:0] b;
    logic       res;
    a = opd_byte(w.opd1, p);
    b = opd_byte(w.opd2, p);
    case (w.op)
        2'b00:   res = (a > b);
        2'b01:   res = (a >= b);
        2'b10:   res = (a == b);
        default: res = 1'b1;
    endcase
    return res;
endfunction

// operand mixes for the compare test, some built to be equal
function automatic com_word_t pred_word(logic [1:0] op, int combo, phv_t p);
    logic [31:0] r;
    operand_t    a;
    operand_t    b;
    r = rand_bits(16);
    case (combo)
        0: begin a = make_imm(r[7:0]); b = make_imm(r[7:0]); end
        1: begin a = make_imm(r[7:0]); b = make_imm(r[15:8]); end
        2: begin a = make_ref(2'b10, r[2:0]); b = make_imm(p.c6[r[2:0]][7:0]); end
        3: begin a = make_ref(2'b01, r[2:0]); b = make_ref(2'b00, r[5:3]); end
        4: begin a = make_ref(2'b11, r[2:0]); b = make_imm(8'h00); end
        default: begin a = make_imm(r[7:0]); b = make_ref(2'b11, r[5:3]); end
    endcase
    return {op, a, b};
endfunction

// expected outputs for one input item, from the model tables
function automatic exp_item_t model_item(phv_t p, logic v);
    exp_item_t  it;
    off_entry_t oe;
    logic [3:0] t;
    t = p[`TENANT_LSB +: 4];
    oe = off_model[t];
    it.valid = v;
    it.phv = p;
    it.mask = mask_model[t];
    it.key = '0;
    if (v) begin
        it.key.f6 = p.c6[oe.idx_6b];
        it.key.f4 = p.c4[oe.idx_4b];
        it.key.f2 = p.c2[oe.idx_2b];
        it.key.pred[4-STAGE] = ref_pred(p.com[STAGE], p);
    end
    return it;
endfunction

`endif

/* tb_key_extract.sv */
// testbench top: clock, reset, stimulus, output assertions, timeout and summary
`include "key_extract_defines.svh"

module tb_key_extract
    import key_extract_pkg::*;
();

    localparam int STAGE    = 2;
    localparam int N_WRITES = 6;
    localparam int N_T3     = 24;
    localparam int N_T4     = 24;
    localparam int N_PRED   = 24;
    localparam int N_RAND   = 200;
    // about twice the expected run length
    localparam int CYCLE_LIMIT =
        2 * (2 + 6 + N_WRITES * 6 + N_T3 + N_T4 + N_PRED + N_RAND + 4 + 4 * 5);

    typedef struct packed {
        logic valid;
        phv_t phv;
        key_t key;
        key_t mask;
    } exp_item_t;

    logic       clk;
    logic       rst_n;
    phv_t       phv_in;
    logic       phv_valid_in;
    logic       cfg_req;
    cfg_write_t cfg;
    logic       cfg_ack;
    phv_t       phv_out;
    logic       phv_valid_out;
    key_t       key_out;
    logic       key_valid_out;
    key_t       key_mask_out;

    off_entry_t  off_model [`NUM_TENANT];
    key_t        mask_model [`NUM_TENANT];
    exp_item_t   exp_q[$];
    exp_item_t   exp_cur;
    logic        exp_live;
    logic        ack_prev;
    logic [31:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          errors_at_start;
    int          model_writes;
    int          ack_rises;
    int          cycles;

    `include "tb_key_model.svh"

    key_extract #(
        .STAGE_ID (STAGE)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .cfg_req       (cfg_req),
        .cfg           (cfg),
        .cfg_ack       (cfg_ack),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // model sees the same pre-edge inputs as the DUT, outputs land 2 edges later
    always @(posedge clk or negedge rst_n) begin : model_step
        exp_item_t item;
        if (!rst_n) begin
            exp_q.delete();
            exp_live <= 1'b0;
            ack_prev = 1'b0;
            for (int i = 0; i < `NUM_TENANT; i++) begin
                off_model[i] = '0;
                mask_model[i] = '0;
            end
        end else begin
            item = model_item(phv_in, phv_valid_in);
            if (cfg_ack && !ack_prev) begin
                ack_rises++;
            end
            ack_prev = cfg_ack;
            // table write lands after this edge's read
            if (cfg_req && !cfg_ack) begin
                model_writes++;
                if (cfg.sel_mask) begin
                    mask_model[cfg.tenant] = cfg.mask;
                end else begin
                    off_model[cfg.tenant] = cfg.off;
                end
            end
            exp_q.push_back(item);
            if (exp_q.size() > 2) begin
                exp_cur  <= exp_q.pop_front();
                exp_live <= 1'b1;
            end
        end
    end

    task automatic report_mismatch(string what);
        $display("[FAIL] %0t: %s differs from the model", $time, what);
        errors++;
    endtask

    task automatic report_protocol(string what);
        $display("handshake error at time %0t: %s", $time, what);
        errors++;
    endtask

    phv_match: assert property (@(posedge clk) disable iff (!rst_n)
        exp_live |-> phv_out == exp_cur.phv)
        else report_mismatch("phv_out");
    phv_valid_match: assert property (@(posedge clk) disable iff (!rst_n)
        exp_live |-> phv_valid_out == exp_cur.valid)
        else report_mismatch("phv_valid_out");
    key_valid_match: assert property (@(posedge clk) disable iff (!rst_n)
        exp_live |-> key_valid_out == exp_cur.valid)
        else report_mismatch("key_valid_out");
    key_match: assert property (@(posedge clk) disable iff (!rst_n)
        exp_live |-> key_out == exp_cur.key)
        else report_mismatch("key_out");
    mask_match: assert property (@(posedge clk) disable iff (!rst_n)
        exp_live |-> key_mask_out == exp_cur.mask)
        else report_mismatch("key_mask_out");
    key_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !key_valid_out |-> key_out == '0)
        else report_mismatch("key_out while invalid");
    ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_req && !cfg_ack |=> cfg_ack)
        else report_protocol("cfg_ack did not rise after cfg_req");
    ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_req && cfg_ack |=> cfg_ack)
        else report_protocol("cfg_ack dropped while cfg_req was still high");
    ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg_req |=> !cfg_ack)
        else report_protocol("cfg_ack high without cfg_req");

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            phv_valid_in <= 1'b0;
        end
    endtask

    task automatic send(phv_t p, logic v);
        @(posedge clk);
        phv_in       <= p;
        phv_valid_in <= v;
    endtask

    // four-phase write, returns once ack is low again
    task automatic table_write(logic sel, logic [3:0] t, off_entry_t off, key_t mask);
        cfg_write_t w;
        w.sel_mask = sel;
        w.tenant   = t;
        w.off      = off;
        w.mask     = mask;
        @(posedge clk);
        cfg     <= w;
        cfg_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!cfg_ack);
        cfg_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (cfg_ack);
    endtask

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end else begin
            $display("test %0d %s: no errors", tests_run, name);
        end
    endtask

    initial begin : stimulus
        phv_t        p;
        off_entry_t  oe;
        logic [31:0] r;
        logic [3:0]  used [4];
        rst_n        = 1'b0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        cfg_req      = 1'b0;
        cfg          = '0;
        lfsr_state   = 32'hef057e03;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        begin_test();
        idle(6);
        finish_test("reset idle");

        begin_test();
        used = '{4'd1, 4'd5, 4'd9, 4'd14};
        for (int i = 0; i < 4; i++) begin
            r = rand_bits(9);
            oe = r[8:0];
            table_write(1'b0, used[i], oe, '0);
        end
        idle(4);
        write_count: assert (model_writes == 4 && ack_rises == 4)
            else report_protocol("expected 4 writes and 4 acks for 4 requests");
        finish_test("config handshake");

        // last item is checked on the edge after its output, hence 5 idle cycles
        begin_test();
        for (int i = 0; i < N_T3; i++) begin
            p = random_phv();
            r = rand_bits(2);
            p[`TENANT_LSB +: 4] = used[r[1:0]];
            send(p, 1'b1);
        end
        idle(5);
        finish_test("offset selection");

        begin_test();
        table_write(1'b1, 4'd5, '0, random_key());
        table_write(1'b1, 4'd9, '0, random_key());
        // written tenants 5 and 9 mixed with random ones
        for (int i = 0; i < N_T4; i++) begin
            p = random_phv();
            if (i % 3 == 0) begin
                p[`TENANT_LSB +: 4] = 4'd5;
            end else if (i % 3 == 1) begin
                p[`TENANT_LSB +: 4] = 4'd9;
            end
            send(p, 1'b1);
        end
        idle(5);
        finish_test("mask lookup");

        begin_test();
        for (int op = 0; op < 4; op++) begin
            for (int c = 0; c < 6; c++) begin
                p = random_phv();
                p.com[STAGE] = pred_word(2'(op), c, p);
                send(p, 1'b1);
            end
        end
        idle(5);
        finish_test("predicate compare");

        begin_test();
        for (int i = 0; i < N_RAND; i++) begin
            p = random_phv();
            r = rand_bits(1);
            send(p, r[0]);
        end
        idle(5);
        finish_test("random traffic");

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
